//--- include/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// data word width.
`define WB_XLEN 32

// general register count including x0.
`define WB_GPR_COUNT 32

// mcause, mepc, mstatus, mtvec.
`define WB_CSR_COUNT 4

// entries per lane queue and credits a lane starts with.
`define WB_QUEUE_DEPTH 4

// register copied into mcause on ecall.
`define WB_ECALL_SRC 15

`endif

//--- rtl/wb_pkg.sv
`default_nettype none

`include "wb_settings.svh"

package wb_pkg;

  typedef logic [`WB_XLEN-1:0] word_t;

  typedef logic [$clog2(`WB_GPR_COUNT)-1:0] gpr_addr_t;

  typedef logic [$clog2(`WB_CSR_COUNT)-1:0] csr_addr_t;

  // machine CSR slots.
  typedef enum logic [1:0] {
    CSR_MCAUSE  = 2'd0,
    CSR_MEPC    = 2'd1,
    CSR_MSTATUS = 2'd2,
    CSR_MTVEC   = 2'd3
  } csr_idx_e;

  // integer lane record for general writes only.
  typedef struct packed {
    gpr_addr_t rd;
    word_t     wd;
  } gpr_wb_t;

  // system lane record.
  typedef struct packed {
    logic      reg_we;
    gpr_addr_t rd;
    word_t     wd;
    logic      csr_we;
    csr_addr_t csr_rd;
    word_t     csr_wd;
    logic      ecall;
  } sys_wb_t;

endpackage

`default_nettype wire

//--- rtl/wb_credit_queue.sv
`default_nettype none

`include "wb_settings.svh"

module wb_credit_queue #(
  parameter type payload_t = logic [`WB_XLEN-1:0],
  parameter int  DEPTH     = `WB_QUEUE_DEPTH
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     push,
  input  wire payload_t push_data,
  input  wire logic     pop,
  output logic          head_valid,
  output payload_t      head_data,
  output logic          credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // a pop on an empty queue is ignored.
  assign do_pop     = pop && head_valid;
  assign head_valid = (count != '0);
  assign head_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  // the producer pushes only while it holds a credit.
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit back per popped entry.
  always_ff @(posedge clk) begin
    if (reset) begin
      credit <= 1'b0;
    end else begin
      credit <= do_pop;
    end
  end

endmodule

`default_nettype wire

//--- rtl/wb_arbiter.sv
`default_nettype none

module wb_arbiter
  import wb_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire logic    gpr_valid,
  input  wire gpr_wb_t gpr_head,
  input  wire logic    sys_valid,
  input  wire sys_wb_t sys_head,
  output logic         gpr_pop,
  output logic         sys_pop,
  output logic         write_valid,
  output logic         reg_write_en,
  output gpr_addr_t    rd,
  output word_t        wd,
  output logic         csreg_write_en,
  output csr_addr_t    csr_rd,
  output word_t        csr_wd,
  output logic         ecall
);

  // high when the system lane wins the next tie.
  logic prefer_sys;

  always_comb begin
    if (gpr_valid && sys_valid) begin
      gpr_pop = !prefer_sys;
      sys_pop = prefer_sys;
    end else begin
      gpr_pop = gpr_valid;
      sys_pop = sys_valid;
    end
  end

  assign write_valid = gpr_pop || sys_pop;

  // unpack the winner onto the write command.
  always_comb begin
    reg_write_en   = 1'b0;
    rd             = gpr_head.rd;
    wd             = gpr_head.wd;
    csreg_write_en = 1'b0;
    csr_rd         = sys_head.csr_rd;
    csr_wd         = sys_head.csr_wd;
    ecall          = 1'b0;
    if (gpr_pop) begin
      reg_write_en = 1'b1;
    end else if (sys_pop) begin
      reg_write_en   = sys_head.reg_we;
      rd             = sys_head.rd;
      wd             = sys_head.wd;
      csreg_write_en = sys_head.csr_we;
      ecall          = sys_head.ecall;
    end
  end

  // integer lane is favoured out of reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      prefer_sys <= 1'b0;
    end else if (gpr_pop) begin
      prefer_sys <= 1'b1;
    end else if (sys_pop) begin
      prefer_sys <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/wbu.sv
`default_nettype none

`include "wb_settings.svh"

module wbu
  import wb_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      write_valid,
  input  wire gpr_addr_t rs1,
  input  wire gpr_addr_t rs2,
  input  wire csr_addr_t csr_rs,
  input  wire gpr_addr_t rd,
  input  wire csr_addr_t csr_rd,
  input  wire word_t     wd,
  input  wire word_t     csr_wd,
  input  wire logic      reg_write_en,
  input  wire logic      csreg_write_en,
  input  wire logic      ecall,
  output word_t          rsa,
  output word_t          rsb,
  output word_t          csra
);

  localparam int GPR_N = `WB_GPR_COUNT;
  localparam int CSR_N = `WB_CSR_COUNT;

  word_t gpr_q [GPR_N];
  word_t gpr_d [GPR_N];

  // indexed by csr_idx_e.
  word_t csr_q [CSR_N];
  word_t csr_d [CSR_N];

  // next state of both arrays.
  always_comb begin
    gpr_d = gpr_q;
    csr_d = csr_q;
    if (write_valid) begin
      if (reg_write_en) begin
        gpr_d[rd] = wd;
      end
      if (csreg_write_en) begin
        csr_d[csr_rd] = csr_wd;
      end
      // ecall wins over a csr write to mcause.
      if (ecall) begin
        csr_d[CSR_MCAUSE] = gpr_q[`WB_ECALL_SRC];
      end
    end
    // x0 stays zero.
    gpr_d[0] = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < GPR_N; i++) begin
        gpr_q[i] <= '0;
      end
    end else begin
      gpr_q <= gpr_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < CSR_N; i++) begin
        csr_q[i] <= '0;
      end
    end else begin
      csr_q <= csr_d;
    end
  end

  // combinational reads.
  assign rsa  = gpr_q[rs1];
  assign rsb  = gpr_q[rs2];
  assign csra = csr_q[csr_rs];

endmodule

`default_nettype wire

//--- rtl/wb_top.sv
`default_nettype none

`include "wb_settings.svh"

module wb_top
  import wb_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  // integer lane.
  input  wire logic      gpr_push,
  input  wire gpr_addr_t gpr_rd,
  input  wire word_t     gpr_wd,
  output logic           gpr_credit,
  // system lane.
  input  wire logic      sys_push,
  input  wire logic      sys_reg_we,
  input  wire gpr_addr_t sys_rd,
  input  wire word_t     sys_wd,
  input  wire logic      sys_csr_we,
  input  wire csr_addr_t sys_csr_rd,
  input  wire word_t     sys_csr_wd,
  input  wire logic      sys_ecall,
  output logic           sys_credit,
  // read ports.
  input  wire gpr_addr_t rs1,
  input  wire gpr_addr_t rs2,
  input  wire csr_addr_t csr_rs,
  output word_t          rsa,
  output word_t          rsb,
  output word_t          csra
);

  gpr_wb_t   gpr_in;
  gpr_wb_t   gpr_head;
  logic      gpr_head_valid;
  logic      gpr_pop;

  sys_wb_t   sys_in;
  sys_wb_t   sys_head;
  logic      sys_head_valid;
  logic      sys_pop;

  logic      wb_valid;
  logic      wb_reg_we;
  gpr_addr_t wb_rd;
  word_t     wb_wd;
  logic      wb_csr_we;
  csr_addr_t wb_csr_rd;
  word_t     wb_csr_wd;
  logic      wb_ecall;

  assign gpr_in.rd = gpr_rd;
  assign gpr_in.wd = gpr_wd;

  assign sys_in.reg_we = sys_reg_we;
  assign sys_in.rd     = sys_rd;
  assign sys_in.wd     = sys_wd;
  assign sys_in.csr_we = sys_csr_we;
  assign sys_in.csr_rd = sys_csr_rd;
  assign sys_in.csr_wd = sys_csr_wd;
  assign sys_in.ecall  = sys_ecall;

  wb_credit_queue #(
    .payload_t (gpr_wb_t),
    .DEPTH     (`WB_QUEUE_DEPTH)
  ) u_gpr_queue (
    .clk        (clk),
    .reset      (reset),
    .push       (gpr_push),
    .push_data  (gpr_in),
    .pop        (gpr_pop),
    .head_valid (gpr_head_valid),
    .head_data  (gpr_head),
    .credit     (gpr_credit)
  );

  wb_credit_queue #(
    .payload_t (sys_wb_t),
    .DEPTH     (`WB_QUEUE_DEPTH)
  ) u_sys_queue (
    .clk        (clk),
    .reset      (reset),
    .push       (sys_push),
    .push_data  (sys_in),
    .pop        (sys_pop),
    .head_valid (sys_head_valid),
    .head_data  (sys_head),
    .credit     (sys_credit)
  );

  wb_arbiter u_arbiter (
    .clk            (clk),
    .reset          (reset),
    .gpr_valid      (gpr_head_valid),
    .gpr_head       (gpr_head),
    .sys_valid      (sys_head_valid),
    .sys_head       (sys_head),
    .gpr_pop        (gpr_pop),
    .sys_pop        (sys_pop),
    .write_valid    (wb_valid),
    .reg_write_en   (wb_reg_we),
    .rd             (wb_rd),
    .wd             (wb_wd),
    .csreg_write_en (wb_csr_we),
    .csr_rd         (wb_csr_rd),
    .csr_wd         (wb_csr_wd),
    .ecall          (wb_ecall)
  );

  wbu u_wbu (
    .clk            (clk),
    .reset          (reset),
    .write_valid    (wb_valid),
    .rs1            (rs1),
    .rs2            (rs2),
    .csr_rs         (csr_rs),
    .rd             (wb_rd),
    .csr_rd         (wb_csr_rd),
    .wd             (wb_wd),
    .csr_wd         (wb_csr_wd),
    .reg_write_en   (wb_reg_we),
    .csreg_write_en (wb_csr_we),
    .ecall          (wb_ecall),
    .rsa            (rsa),
    .rsb            (rsb),
    .csra           (csra)
  );

endmodule

`default_nettype wire

//--- verif/wb_tb.sv
`default_nettype none

`include "wb_settings.svh"

module wb_tb
  import wb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH         = `WB_QUEUE_DEPTH;
  localparam int WAIT_LIMIT    = 200;
  localparam int RANDOM_CYCLES = 300;
  localparam int FULL_RECORDS  = 16;

  logic      clk;
  logic      reset;
  logic      gpr_push;
  gpr_addr_t gpr_rd;
  word_t     gpr_wd;
  logic      gpr_credit;
  logic      sys_push;
  logic      sys_reg_we;
  gpr_addr_t sys_rd;
  word_t     sys_wd;
  logic      sys_csr_we;
  csr_addr_t sys_csr_rd;
  word_t     sys_csr_wd;
  logic      sys_ecall;
  logic      sys_credit;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  csr_addr_t csr_rs;
  word_t     rsa;
  word_t     rsb;
  word_t     csra;

  // expected register state.
  word_t model_gpr [`WB_GPR_COUNT];
  word_t model_csr [`WB_CSR_COUNT];

  int gpr_credits;
  int sys_credits;
  int gpr_pushes;
  int sys_pushes;
  int gpr_pulses;
  int sys_pulses;
  bit log_pulses;
  bit pulse_log [$];
  // lane of the most recent credit pulse.
  bit last_sys;

  wb_top u_wb_top (
    .clk        (clk),
    .reset      (reset),
    .gpr_push   (gpr_push),
    .gpr_rd     (gpr_rd),
    .gpr_wd     (gpr_wd),
    .gpr_credit (gpr_credit),
    .sys_push   (sys_push),
    .sys_reg_we (sys_reg_we),
    .sys_rd     (sys_rd),
    .sys_wd     (sys_wd),
    .sys_csr_we (sys_csr_we),
    .sys_csr_rd (sys_csr_rd),
    .sys_csr_wd (sys_csr_wd),
    .sys_ecall  (sys_ecall),
    .sys_credit (sys_credit),
    .rs1        (rs1),
    .rs2        (rs2),
    .csr_rs     (csr_rs),
    .rsa        (rsa),
    .rsb        (rsb),
    .csra       (csra)
  );

  always #2 clk = ~clk;

  task automatic report_value(input string name, input word_t expected, input word_t actual);
    $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
    $display("FAIL: see errors above");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "check failed");
  endtask

  // applies one record by the write rules.
  // ecall reads x15 as it was before the record.
  function automatic void apply_ref(input logic reg_we, input gpr_addr_t rd, input word_t wd,
                                    input logic csr_we, input csr_addr_t csr_rd,
                                    input word_t csr_wd, input logic ecall);
    word_t ecall_src;
    ecall_src = model_gpr[`WB_ECALL_SRC];
    if (reg_we && rd != '0) begin
      model_gpr[rd] = wd;
    end
    if (csr_we) begin
      model_csr[csr_rd] = csr_wd;
    end
    if (ecall) begin
      model_csr[CSR_MCAUSE] = ecall_src;
    end
  endfunction

  // credit pulses are stable around the falling edge.
  always @(negedge clk) begin
    if (!reset) begin
      assert (!(gpr_credit && sys_credit))
        else report_failure("both lanes returned a credit in the same cycle");
      if (gpr_credit) begin
        gpr_credits++;
        gpr_pulses++;
        last_sys = 1'b0;
        if (log_pulses) begin
          pulse_log.push_back(1'b0);
        end
      end
      if (sys_credit) begin
        sys_credits++;
        sys_pulses++;
        last_sys = 1'b1;
        if (log_pulses) begin
          pulse_log.push_back(1'b1);
        end
      end
      assert (gpr_credits <= DEPTH) else report_failure("integer lane credits exceed queue depth");
      assert (sys_credits <= DEPTH) else report_failure("system lane credits exceed queue depth");
    end
  end

  task automatic step();
    @(posedge clk);
    #0.5;
    gpr_push = 1'b0;
    sys_push = 1'b0;
  endtask

  task automatic set_gpr(input gpr_addr_t rd, input word_t wd);
    gpr_push = 1'b1;
    gpr_rd   = rd;
    gpr_wd   = wd;
    gpr_credits--;
    gpr_pushes++;
    apply_ref(1'b1, rd, wd, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic set_sys(input logic reg_we, input gpr_addr_t rd, input word_t wd,
                         input logic csr_we, input csr_addr_t csr_rd, input word_t csr_wd,
                         input logic ecall);
    sys_push   = 1'b1;
    sys_reg_we = reg_we;
    sys_rd     = rd;
    sys_wd     = wd;
    sys_csr_we = csr_we;
    sys_csr_rd = csr_rd;
    sys_csr_wd = csr_wd;
    sys_ecall  = ecall;
    sys_credits--;
    sys_pushes++;
    apply_ref(reg_we, rd, wd, csr_we, csr_rd, csr_wd, ecall);
  endtask

  task automatic wait_credit(input bit sys_lane);
    int waited;
    waited = 0;
    while ((sys_lane ? sys_credits : gpr_credits) == 0) begin
      if (waited == WAIT_LIMIT) begin
        report_failure("timed out waiting for a lane credit");
      end
      step();
      waited++;
    end
  endtask

  task automatic push_gpr(input gpr_addr_t rd, input word_t wd);
    wait_credit(1'b0);
    set_gpr(rd, wd);
    step();
  endtask

  task automatic push_sys(input logic reg_we, input gpr_addr_t rd, input word_t wd,
                          input logic csr_we, input csr_addr_t csr_rd, input word_t csr_wd,
                          input logic ecall);
    wait_credit(1'b1);
    set_sys(reg_we, rd, wd, csr_we, csr_rd, csr_wd, ecall);
    step();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (gpr_credits != DEPTH || sys_credits != DEPTH) begin
      if (waited == WAIT_LIMIT) begin
        report_failure("timed out waiting for all credits to return");
      end
      step();
      waited++;
    end
  endtask

  task automatic check_state();
    int j;
    for (int i = 0; i < `WB_GPR_COUNT; i++) begin
      j      = `WB_GPR_COUNT - 1 - i;
      rs1    = gpr_addr_t'(i);
      rs2    = gpr_addr_t'(j);
      csr_rs = csr_addr_t'(i % `WB_CSR_COUNT);
      @(negedge clk);
      assert (rsa === model_gpr[i])
        else report_value($sformatf("rsa (x%0d)", i), model_gpr[i], rsa);
      assert (rsb === model_gpr[j])
        else report_value($sformatf("rsb (x%0d)", j), model_gpr[j], rsb);
      assert (csra === model_csr[i % `WB_CSR_COUNT])
        else report_value($sformatf("csra (csr %0d)", i % `WB_CSR_COUNT),
                          model_csr[i % `WB_CSR_COUNT], csra);
      step();
    end
  endtask

  initial begin
    int gpr_sent;
    int sys_sent;
    int waited;
    bit sys_first;
    void'($urandom(14551));
    clk        = 1'b0;
    reset      = 1'b1;
    gpr_push   = 1'b0;
    gpr_rd     = '0;
    gpr_wd     = '0;
    sys_push   = 1'b0;
    sys_reg_we = 1'b0;
    sys_rd     = '0;
    sys_wd     = '0;
    sys_csr_we = 1'b0;
    sys_csr_rd = '0;
    sys_csr_wd = '0;
    sys_ecall  = 1'b0;
    rs1        = '0;
    rs2        = '0;
    csr_rs     = '0;
    log_pulses = 1'b0;
    // the integer lane is favoured out of reset.
    last_sys    = 1'b1;
    gpr_credits = DEPTH;
    sys_credits = DEPTH;
    gpr_pushes  = 0;
    sys_pushes  = 0;
    gpr_pulses  = 0;
    sys_pulses  = 0;
    foreach (model_gpr[i]) model_gpr[i] = '0;
    foreach (model_csr[i]) model_csr[i] = '0;
    repeat (4) @(posedge clk);
    #0.5;
    reset = 1'b0;

    // all zero out of reset, and no credits while idle.
    check_state();
    assert (gpr_pulses == 0 && sys_pulses == 0)
      else report_failure("credit pulse seen with nothing pushed");

    // back to back integer writes, repeats and x0.
    push_gpr(5'd3, 32'h1111_0003);
    push_gpr(5'd3, 32'h2222_0003);
    push_gpr(5'd0, 32'hFFFF_FFFF);
    push_gpr(5'd7, 32'h3333_0007);
    push_gpr(5'd3, 32'h4444_0003);
    push_gpr(5'd0, 32'h0BAD_0000);
    push_gpr(5'd31, 32'h5555_001F);
    drain();
    check_state();

    // combined general and csr writes on all four csrs.
    push_sys(1'b1, 5'd16, 32'hA000_0010, 1'b1, CSR_MCAUSE, 32'hC000_0000, 1'b0);
    push_sys(1'b1, 5'd19, 32'hA000_0013, 1'b1, CSR_MEPC, 32'hC000_0001, 1'b0);
    push_sys(1'b0, 5'd22, 32'hDEAD_0016, 1'b1, CSR_MSTATUS, 32'hC000_0002, 1'b0);
    push_sys(1'b1, 5'd0, 32'hDEAD_0000, 1'b1, CSR_MTVEC, 32'hC000_0003, 1'b0);
    push_sys(1'b1, 5'd25, 32'hA000_0019, 1'b0, CSR_MEPC, 32'hDEAD_0001, 1'b0);
    drain();
    check_state();

    // ecall copies x15 over a same-record mcause write.
    push_gpr(5'd15, 32'h8000_000B);
    drain();
    push_sys(1'b1, 5'd20, 32'h2020_2020, 1'b1, CSR_MCAUSE, 32'hDEAD_BEEF, 1'b1);
    drain();
    check_state();

    // random traffic on both lanes with disjoint destinations.
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      if (gpr_credits != 0 && $urandom % 2 == 1) begin
        set_gpr(gpr_addr_t'(1 + $urandom % 15), word_t'($urandom));
      end
      if (sys_credits != 0 && $urandom % 2 == 1) begin
        set_sys($urandom % 2 != 0, gpr_addr_t'(16 + $urandom % 16), word_t'($urandom),
                $urandom % 2 != 0, csr_addr_t'($urandom % 4), word_t'($urandom), 1'b0);
      end
      step();
    end
    drain();
    assert (gpr_pulses == gpr_pushes)
      else report_value("gpr_credit pulses", word_t'(gpr_pushes), word_t'(gpr_pulses));
    assert (sys_pulses == sys_pushes)
      else report_value("sys_credit pulses", word_t'(sys_pushes), word_t'(sys_pulses));
    check_state();

    // both queues kept full.
    gpr_sent = 0;
    sys_sent = 0;
    waited   = 0;
    // the first tie goes to the lane not served last.
    sys_first = !last_sys;
    pulse_log.delete();
    log_pulses = 1'b1;
    while (gpr_sent < FULL_RECORDS || sys_sent < FULL_RECORDS) begin
      if (waited == WAIT_LIMIT) begin
        report_failure("timed out keeping both queues full");
      end
      if (gpr_credits != 0 && gpr_sent < FULL_RECORDS) begin
        set_gpr(gpr_addr_t'(1 + gpr_sent % 15), word_t'(32'h6000_0000 + gpr_sent));
        gpr_sent++;
      end
      if (sys_credits != 0 && sys_sent < FULL_RECORDS) begin
        set_sys(1'b1, gpr_addr_t'(16 + sys_sent % 16), word_t'(32'h7000_0000 + sys_sent),
                1'b1, csr_addr_t'(sys_sent % 4), word_t'(32'h7100_0000 + sys_sent), 1'b0);
        sys_sent++;
      end
      step();
      waited++;
    end
    drain();
    log_pulses = 1'b0;
    assert (pulse_log.size() == 2 * FULL_RECORDS)
      else report_value("credit pulse count", word_t'(2 * FULL_RECORDS),
                        word_t'(pulse_log.size()));
    assert (pulse_log[0] == sys_first)
      else report_failure("first tie was not granted to the lane served least recently");
    for (int i = 1; i < pulse_log.size(); i++) begin
      assert (pulse_log[i] != pulse_log[i-1])
        else report_failure("credit pulses did not alternate between the lanes");
    end
    check_state();

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
rtl/wb_pkg.sv
rtl/wb_credit_queue.sv
rtl/wb_arbiter.sv
rtl/wbu.sv
rtl/wb_top.sv
verif/wb_tb.sv

//--- run.sh
#!/bin/sh
# build and run the writeback stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module wb_tb -o wb_sim

status=0
output=$(./obj_dir/wb_sim 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q '^PASS: all tests$'; then
  exit 0
fi
echo "simulation failed (exit status $status)"
exit 1
